// ==== logic/voxel_shell_pkg.sv ====
package voxel_shell_pkg;

    // ------------------------------
    // Memory address map
    // ------------------------------
    localparam int ADDR_BITS        = 28;
    localparam int DATA_BITS        = 64;
    // Byte lanes inside one 64-bit word
    localparam int WORD_OFFSET_BITS = 3;

    // Voxel window is the low 256 KiB, bits 27..18 must be zero
    localparam logic [ADDR_BITS-1:0] VOXEL_WIN_BASE = 28'h000_0000;
    localparam logic [ADDR_BITS-1:0] VOXEL_WIN_MASK = 28'hFFC_0000;
    localparam int                   VOX_WORD_BITS  = 15;

    // On-chip SDRAM stand-in, 1024 x 64-bit words
    localparam logic [ADDR_BITS-1:0] SDRAM_BASE      = 28'h004_0000;
    localparam int                   SDRAM_WORD_BITS = 10;
    localparam int                   SDRAM_BYTE_BITS = SDRAM_WORD_BITS + WORD_OFFSET_BITS;

    // ------------------------------
    // Screen geometry
    // ------------------------------
    localparam int SCREEN_WIDTH  = 480;
    localparam int SCREEN_HEIGHT = 360;
    localparam int TOTAL_PIXELS  = SCREEN_WIDTH * SCREEN_HEIGHT;
    localparam int PIX_ADDR_BITS = 18;
    localparam int RGB_BITS      = 24;
    localparam int COUNT_BITS    = 32;

    localparam logic [PIX_ADDR_BITS-1:0] LAST_PIXEL = PIX_ADDR_BITS'(TOTAL_PIXELS - 1);

    // ------------------------------
    // Enums
    // ------------------------------
    typedef enum logic {MEM_READ = 1'b0, MEM_WRITE = 1'b1} mem_op_e;

    // AXI response codes
    typedef enum logic [1:0] {RESP_OKAY = 2'b00, RESP_DECERR = 2'b11} mem_resp_e;

    typedef enum logic [1:0] {TGT_VOXEL, TGT_SDRAM, TGT_NONE} mem_target_e;

    // Four-phase acceptor state
    typedef enum logic {HS_IDLE, HS_HOLD} hs_state_e;

    // ------------------------------
    // Structs
    // ------------------------------
    typedef struct packed {
        mem_op_e                op;
        logic [ADDR_BITS-1:0]   addr;
        logic [DATA_BITS-1:0]   wdata;
    } mem_cmd_t;

    typedef struct packed {
        logic [DATA_BITS-1:0]   rdata;
        mem_resp_e              resp;
    } mem_rsp_t;

    // Decode to access stage link
    typedef struct packed {
        logic                       valid;
        mem_op_e                    op;
        mem_target_e                target;
        logic [SDRAM_WORD_BITS-1:0] word;
        logic [DATA_BITS-1:0]       wdata;
    } mem_stage_t;

    typedef struct packed {
        logic                       en;
        logic [VOX_WORD_BITS-1:0]   addr;
        logic [DATA_BITS-1:0]       data;
    } vox_wr_t;

    typedef struct packed {
        logic [PIX_ADDR_BITS-1:0]   addr;
        logic [RGB_BITS-1:0]        rgb;
    } pixel_t;

    typedef struct packed {
        logic [RGB_BITS-1:0]        rgb;
        logic                       sof;
        logic                       eof;
    } stream_beat_t;

endpackage

// ==== logic/window_decode.sv ====
`timescale 1ns/1ps

module window_decode (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          mem_req,
    input  voxel_shell_pkg::mem_cmd_t     mem_cmd,
    output voxel_shell_pkg::mem_stage_t   stage,
    output voxel_shell_pkg::vox_wr_t      vox_wr
);

    logic                                          req_q;
    logic                                          req_rise;
    logic                                          in_voxel;
    logic                                          in_sdram;
    logic [voxel_shell_pkg::ADDR_BITS-1:0]         sdram_off;
    voxel_shell_pkg::mem_target_e                  target_d;

    // Registered stage fields
    logic                                          valid_q;
    voxel_shell_pkg::mem_op_e                      op_q;
    voxel_shell_pkg::mem_target_e                  target_q;
    logic [voxel_shell_pkg::SDRAM_WORD_BITS-1:0]   word_q;
    logic [voxel_shell_pkg::DATA_BITS-1:0]         wdata_q;
    logic                                          vox_en_q;
    logic [voxel_shell_pkg::VOX_WORD_BITS-1:0]     vox_addr_q;

    // Only a fresh request is taken, the held level is ignored
    assign req_rise = mem_req && !req_q;

    // ------------------------------
    // Address classification
    // ------------------------------
    assign in_voxel = (mem_cmd.addr & voxel_shell_pkg::VOXEL_WIN_MASK)
                      == voxel_shell_pkg::VOXEL_WIN_BASE;

    assign sdram_off = mem_cmd.addr - voxel_shell_pkg::SDRAM_BASE;
    assign in_sdram  = (mem_cmd.addr >= voxel_shell_pkg::SDRAM_BASE) &&
                       ((sdram_off >> voxel_shell_pkg::SDRAM_BYTE_BITS) == '0);

    always_comb begin
        if (in_voxel) begin
            target_d = voxel_shell_pkg::TGT_VOXEL;
        end else if (in_sdram) begin
            target_d = voxel_shell_pkg::TGT_SDRAM;
        end else begin
            target_d = voxel_shell_pkg::TGT_NONE;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_q    <= 1'b0;
            valid_q  <= 1'b0;
            vox_en_q <= 1'b0;
        end else begin
            req_q    <= mem_req;
            valid_q  <= req_rise;
            // Voxel write port strobes for exactly one cycle
            vox_en_q <= req_rise && (target_d == voxel_shell_pkg::TGT_VOXEL) &&
                        (mem_cmd.op == voxel_shell_pkg::MEM_WRITE);
        end
    end

    always_ff @(posedge clk) begin
        if (req_rise) begin
            op_q       <= mem_cmd.op;
            target_q   <= target_d;
            word_q     <= sdram_off[voxel_shell_pkg::SDRAM_BYTE_BITS-1:
                                    voxel_shell_pkg::WORD_OFFSET_BITS];
            wdata_q    <= mem_cmd.wdata;
            vox_addr_q <= mem_cmd.addr[voxel_shell_pkg::VOX_WORD_BITS +
                                       voxel_shell_pkg::WORD_OFFSET_BITS - 1:
                                       voxel_shell_pkg::WORD_OFFSET_BITS];
        end
    end

    assign stage  = '{valid: valid_q, op: op_q, target: target_q,
                      word: word_q, wdata: wdata_q};
    assign vox_wr = '{en: vox_en_q, addr: vox_addr_q, data: wdata_q};

endmodule

// ==== logic/mem_access.sv ====
`timescale 1ns/1ps

module mem_access (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          mem_req,
    input  voxel_shell_pkg::mem_stage_t   stage,
    output logic                          mem_ack,
    output voxel_shell_pkg::mem_rsp_t     mem_rsp
);

    voxel_shell_pkg::hs_state_e               ack_state;

    // SDRAM stand-in storage
    logic [voxel_shell_pkg::DATA_BITS-1:0]    sdram_mem [2**voxel_shell_pkg::SDRAM_WORD_BITS];

    logic [voxel_shell_pkg::DATA_BITS-1:0]    rdata_q;
    voxel_shell_pkg::mem_resp_e               resp_q;

    // ------------------------------
    // Array access and response
    // ------------------------------
    always_ff @(posedge clk) begin
        if (stage.valid) begin
            case (stage.target)
                voxel_shell_pkg::TGT_SDRAM: begin
                    if (stage.op == voxel_shell_pkg::MEM_WRITE) begin
                        sdram_mem[stage.word] <= stage.wdata;
                        rdata_q               <= '0;
                    end else begin
                        rdata_q <= sdram_mem[stage.word];
                    end
                    resp_q <= voxel_shell_pkg::RESP_OKAY;
                end
                // Voxel window is write-only, reads come back as zero
                voxel_shell_pkg::TGT_VOXEL: begin
                    rdata_q <= '0;
                    resp_q  <= voxel_shell_pkg::RESP_OKAY;
                end
                default: begin
                    rdata_q <= '0;
                    resp_q  <= voxel_shell_pkg::RESP_DECERR;
                end
            endcase
        end
    end

    // ------------------------------
    // Four-phase ack
    // ------------------------------
    // Ack rises with the response and holds until the host drops its request
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_state <= voxel_shell_pkg::HS_IDLE;
        end else begin
            case (ack_state)
                voxel_shell_pkg::HS_IDLE: begin
                    if (stage.valid) begin
                        ack_state <= voxel_shell_pkg::HS_HOLD;
                    end
                end
                voxel_shell_pkg::HS_HOLD: begin
                    if (!mem_req) begin
                        ack_state <= voxel_shell_pkg::HS_IDLE;
                    end
                end
                default: ack_state <= voxel_shell_pkg::HS_IDLE;
            endcase
        end
    end

    assign mem_ack = (ack_state == voxel_shell_pkg::HS_HOLD);
    assign mem_rsp = '{rdata: rdata_q, resp: resp_q};

endmodule

// ==== logic/pixel_framer.sv ====
`timescale 1ns/1ps

module pixel_framer (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            pix_req,
    input  voxel_shell_pkg::pixel_t         pixel,
    input  logic                            beat_room,
    output logic                            pix_ack,
    output logic                            load,
    output voxel_shell_pkg::stream_beat_t   beat
);

    voxel_shell_pkg::hs_state_e state;
    logic                       accept;
    logic                       is_first;
    logic                       is_last;

    // Take the pixel only when the output register can hold it
    assign accept = (state == voxel_shell_pkg::HS_IDLE) && pix_req && beat_room;

    // ------------------------------
    // Four-phase acceptor
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= voxel_shell_pkg::HS_IDLE;
        end else begin
            case (state)
                voxel_shell_pkg::HS_IDLE: begin
                    if (accept) begin
                        state <= voxel_shell_pkg::HS_HOLD;
                    end
                end
                // Wait for the source to release its request
                voxel_shell_pkg::HS_HOLD: begin
                    if (!pix_req) begin
                        state <= voxel_shell_pkg::HS_IDLE;
                    end
                end
                default: state <= voxel_shell_pkg::HS_IDLE;
            endcase
        end
    end

    assign pix_ack = (state == voxel_shell_pkg::HS_HOLD);
    assign load    = accept;

    // Frame markers come from the linear pixel address
    assign is_first = (pixel.addr == '0);
    assign is_last  = (pixel.addr == voxel_shell_pkg::LAST_PIXEL);

    assign beat = '{rgb: pixel.rgb, sof: is_first, eof: is_last};

endmodule

// ==== logic/pixel_stream_out.sv ====
`timescale 1ns/1ps

module pixel_stream_out (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    load,
    input  voxel_shell_pkg::stream_beat_t           beat,
    input  logic                                    stream_ready,
    output logic                                    beat_room,
    output logic                                    stream_valid,
    output voxel_shell_pkg::stream_beat_t           stream_beat,
    output logic [voxel_shell_pkg::COUNT_BITS-1:0]  beat_count,
    output logic [voxel_shell_pkg::COUNT_BITS-1:0]  frame_count
);

    logic                           valid_q;
    voxel_shell_pkg::stream_beat_t  beat_q;
    logic                           xfer;

    assign xfer = valid_q && stream_ready;

    // Room when empty or when the held beat leaves this cycle
    assign beat_room = !valid_q || xfer;

    // ------------------------------
    // Held output beat
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            if (load) begin
                valid_q <= 1'b1;
            end else if (xfer) begin
                valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            beat_q <= beat;
        end
    end

    assign stream_valid = valid_q;
    assign stream_beat  = beat_q;

    // ------------------------------
    // Beat and frame counters
    // ------------------------------
    // Both wrap freely at full width
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_count  <= '0;
            frame_count <= '0;
        end else if (xfer) begin
            beat_count <= beat_count + 1'b1;
            if (beat_q.eof) begin
                frame_count <= frame_count + 1'b1;
            end
        end
    end

endmodule

// ==== logic/voxel_shell_top.sv ====
`timescale 1ns/1ps

module voxel_shell_top (
    input  logic                                    clk,
    input  logic                                    rst_n,
    // Host memory port
    input  logic                                    mem_req,
    input  voxel_shell_pkg::mem_cmd_t               mem_cmd,
    output logic                                    mem_ack,
    output voxel_shell_pkg::mem_rsp_t               mem_rsp,
    output voxel_shell_pkg::vox_wr_t                vox_wr,
    // Renderer pixel port
    input  logic                                    pix_req,
    input  voxel_shell_pkg::pixel_t                 pixel,
    output logic                                    pix_ack,
    // Pixel stream out
    output voxel_shell_pkg::stream_beat_t           stream_beat,
    output logic                                    stream_valid,
    input  logic                                    stream_ready,
    output logic [voxel_shell_pkg::COUNT_BITS-1:0]  beat_count,
    output logic [voxel_shell_pkg::COUNT_BITS-1:0]  frame_count
);

    voxel_shell_pkg::mem_stage_t    stage;
    voxel_shell_pkg::stream_beat_t  framed_beat;
    logic                           beat_room;
    logic                           load;

    // ------------------------------
    // Memory pipeline
    // ------------------------------
    window_decode u_decode (
        .clk     (clk),
        .rst_n   (rst_n),
        .mem_req (mem_req),
        .mem_cmd (mem_cmd),
        .stage   (stage),
        .vox_wr  (vox_wr)
    );

    mem_access u_access (
        .clk     (clk),
        .rst_n   (rst_n),
        .mem_req (mem_req),
        .stage   (stage),
        .mem_ack (mem_ack),
        .mem_rsp (mem_rsp)
    );

    // ------------------------------
    // Pixel pipeline
    // ------------------------------
    pixel_framer u_framer (
        .clk       (clk),
        .rst_n     (rst_n),
        .pix_req   (pix_req),
        .pixel     (pixel),
        .beat_room (beat_room),
        .pix_ack   (pix_ack),
        .load      (load),
        .beat      (framed_beat)
    );

    pixel_stream_out u_stream (
        .clk          (clk),
        .rst_n        (rst_n),
        .load         (load),
        .beat         (framed_beat),
        .stream_ready (stream_ready),
        .beat_room    (beat_room),
        .stream_valid (stream_valid),
        .stream_beat  (stream_beat),
        .beat_count   (beat_count),
        .frame_count  (frame_count)
    );

endmodule

// ==== include/shell_vectors.svh ====
`ifndef SHELL_VECTORS_SVH
`define SHELL_VECTORS_SVH

// One row per memory request or pixel
typedef struct packed {
    logic        is_pixel;
    logic        write;
    logic [27:0] addr;          // byte address, or pixel address in the low 18 bits
    logic [63:0] data;          // write data, or rgb in the low 24 bits
    logic [63:0] exp_rdata;
    logic [1:0]  exp_resp;
    logic        exp_vox_en;
    logic [14:0] exp_vox_addr;
    logic        stall;         // Apply random ready-low cycles
    logic        exp_sof;
    logic        exp_eof;
    logic [31:0] exp_beats;
    logic [31:0] exp_frames;
} shell_vec_t;

localparam int SHELL_VEC_COUNT = 14;

localparam shell_vec_t SHELL_VECTORS [SHELL_VEC_COUNT] = '{
    // Two SDRAM words written and read back
    '{1'b0, 1'b1, 28'h004_0000, 64'h1122_3344_5566_7788, 64'h0, 2'd0, 1'b0, 15'h0,
      1'b0, 1'b0, 1'b0, 32'd0, 32'd0},
    '{1'b0, 1'b0, 28'h004_0000, 64'h0, 64'h1122_3344_5566_7788, 2'd0, 1'b0, 15'h0,
      1'b0, 1'b0, 1'b0, 32'd0, 32'd0},
    '{1'b0, 1'b1, 28'h004_1FF8, 64'hA5A5_0000_FFFF_5A5A, 64'h0, 2'd0, 1'b0, 15'h0,
      1'b0, 1'b0, 1'b0, 32'd0, 32'd0},
    '{1'b0, 1'b0, 28'h004_1FF8, 64'h0, 64'hA5A5_0000_FFFF_5A5A, 2'd0, 1'b0, 15'h0,
      1'b0, 1'b0, 1'b0, 32'd0, 32'd0},
    // Unmapped read far above both regions, then word 0 re-read
    '{1'b0, 1'b0, 28'h800_0000, 64'h0, 64'h0, 2'd3, 1'b0, 15'h0,
      1'b0, 1'b0, 1'b0, 32'd0, 32'd0},
    '{1'b0, 1'b0, 28'h004_0000, 64'h0, 64'h1122_3344_5566_7788, 2'd0, 1'b0, 15'h0,
      1'b0, 1'b0, 1'b0, 32'd0, 32'd0},
    // Voxel window read and write
    '{1'b0, 1'b0, 28'h000_0100, 64'h0, 64'h0, 2'd0, 1'b0, 15'h0,
      1'b0, 1'b0, 1'b0, 32'd0, 32'd0},
    '{1'b0, 1'b1, 28'h001_2348, 64'hDEAD_BEEF_0BAD_F00D, 64'h0, 2'd0, 1'b1, 15'h2469,
      1'b0, 1'b0, 1'b0, 32'd0, 32'd0},
    // Unmapped write just past SDRAM leaves word 0 intact
    '{1'b0, 1'b1, 28'h004_2000, 64'hFFFF_FFFF_FFFF_FFFF, 64'h0, 2'd3, 1'b0, 15'h0,
      1'b0, 1'b0, 1'b0, 32'd0, 32'd0},
    '{1'b0, 1'b0, 28'h004_0000, 64'h0, 64'h1122_3344_5566_7788, 2'd0, 1'b0, 15'h0,
      1'b0, 1'b0, 1'b0, 32'd0, 32'd0},
    // Pixels at the first, middle and last address, then the next frame start
    '{1'b1, 1'b1, 28'h000_0000, 64'h10_2030, 64'h0, 2'd0, 1'b0, 15'h0,
      1'b0, 1'b1, 1'b0, 32'd1, 32'd0},
    '{1'b1, 1'b1, 28'h001_5180, 64'h40_5060, 64'h0, 2'd0, 1'b0, 15'h0,
      1'b1, 1'b0, 1'b0, 32'd2, 32'd0},
    '{1'b1, 1'b1, 28'h002_A2FF, 64'h70_8090, 64'h0, 2'd0, 1'b0, 15'h0,
      1'b1, 1'b0, 1'b1, 32'd3, 32'd1},
    '{1'b1, 1'b1, 28'h000_0000, 64'hAB_CDEF, 64'h0, 2'd0, 1'b0, 15'h0,
      1'b0, 1'b1, 1'b0, 32'd4, 32'd1}
};

`endif

// ==== bench/tb_voxel_shell.sv ====
`timescale 1ns/1ps

module tb_voxel_shell;

    `include "shell_vectors.svh"

    localparam int TIMEOUT_CYCLES = SHELL_VEC_COUNT * 20 + 200;
    localparam int ACK_LIMIT      = 16;

    logic                                   clk;
    logic                                   rst_n;
    logic                                   mem_req;
    voxel_shell_pkg::mem_cmd_t              mem_cmd;
    logic                                   mem_ack;
    voxel_shell_pkg::mem_rsp_t              mem_rsp;
    voxel_shell_pkg::vox_wr_t               vox_wr;
    logic                                   pix_req;
    voxel_shell_pkg::pixel_t                pixel;
    logic                                   pix_ack;
    voxel_shell_pkg::stream_beat_t          stream_beat;
    logic                                   stream_valid;
    logic                                   stream_ready;
    logic [voxel_shell_pkg::COUNT_BITS-1:0] beat_count;
    logic [voxel_shell_pkg::COUNT_BITS-1:0] frame_count;

    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          vox_pulses = 0;
    logic [14:0] vox_addr_seen;
    logic [63:0] vox_data_seen;

    voxel_shell_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Voxel write strobes, counted and captured
    always @(negedge clk) begin
        if (vox_wr.en) begin
            vox_pulses    <= vox_pulses + 1;
            vox_addr_seen <= vox_wr.addr;
            vox_data_seen <= vox_wr.data;
        end
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (actual !== expected) begin
            $display("FAILED %s: expected 0x%0h, got 0x%0h", name, expected, actual);
            errors++;
        end
    endtask

    // Waits at falling edges until the chosen ack reaches the level
    task automatic wait_ack(input logic on_mem, input logic level, output int edges);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (((on_mem ? mem_ack : pix_ack) !== level) && n < ACK_LIMIT);
        if ((on_mem ? mem_ack : pix_ack) !== level) begin
            $display("Handshake stuck: %s ack never reached %0d", on_mem ? "mem" : "pixel",
                     level);
            errors++;
        end
        edges = n - 1;
    endtask

    initial begin
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Test failures found");
        $finish;
    end

    initial begin
        shell_vec_t  v;
        int          n;
        int          stall;
        int          vox_before;
        bit          held;
        logic [25:0] exp_beat;
        logic [25:0] prev_beat;
        logic [31:0] final_beats;
        logic [31:0] final_frames;
        stall = $urandom(32'h0f03_a1d8);
        prev_beat = '0;
        final_beats = '0;
        final_frames = '0;
        rst_n = 1'b0;
        mem_req = 1'b0;
        mem_cmd = '0;
        pix_req = 1'b0;
        pixel = '0;
        stream_ready = 1'b1;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        // ------------------------------
        // State right after reset
        // ------------------------------
        @(negedge clk);
        check_value("mem_ack", 0, mem_ack);
        check_value("pix_ack", 0, pix_ack);
        check_value("stream_valid", 0, stream_valid);
        check_value("vox_wr.en", 0, vox_wr.en);
        check_value("beat_count", 0, beat_count);
        check_value("frame_count", 0, frame_count);

        for (int i = 0; i < SHELL_VEC_COUNT; i++) begin
            v = SHELL_VECTORS[i];
            if (!v.is_pixel) begin
                vox_before = vox_pulses;
                @(posedge clk);
                mem_req <= 1'b1;
                mem_cmd <= '{op: voxel_shell_pkg::mem_op_e'(v.write), addr: v.addr,
                             wdata: v.data};
                wait_ack(1'b1, 1'b1, n);
                check_value("mem_ack rise edges", 2, n);
                check_value("mem_rsp.rdata", v.exp_rdata, mem_rsp.rdata);
                check_value("mem_rsp.resp", v.exp_resp, mem_rsp.resp);
                @(posedge clk);
                mem_req <= 1'b0;
                wait_ack(1'b1, 1'b0, n);
                check_value("mem_ack fall edges", 1, n);
                check_value("vox_wr pulses", v.exp_vox_en, vox_pulses - vox_before);
                if (v.exp_vox_en) begin
                    check_value("vox_wr.addr", v.exp_vox_addr, vox_addr_seen);
                    check_value("vox_wr.data", v.data, vox_data_seen);
                end
            end else begin
                // ------------------------------
                // Pixel row, previous beat may still be held
                // ------------------------------
                held = !stream_ready;
                @(posedge clk);
                pix_req <= 1'b1;
                pixel   <= '{addr: v.addr[17:0], rgb: v.data[23:0]};
                if (v.stall && !held) begin
                    stream_ready <= 1'b0;
                end
                if (held) begin
                    stall = $urandom % 4;
                    repeat (stall) begin
                        @(negedge clk);
                        check_value("pix_ack", 0, pix_ack);
                        check_value("stream_valid", 1, stream_valid);
                        check_value("stream_beat", prev_beat, stream_beat);
                    end
                    @(posedge clk);
                    stream_ready <= 1'b1;
                    // Held beat leaves and the new one loads on this edge
                    @(posedge clk);
                    if (v.stall) begin
                        stream_ready <= 1'b0;
                    end
                end
                wait_ack(1'b0, 1'b1, n);
                exp_beat = {v.data[23:0], v.exp_sof, v.exp_eof};
                check_value("stream_valid", 1, stream_valid);
                check_value("stream_beat", exp_beat, stream_beat);
                check_value("beat_count", v.exp_beats - 1, beat_count);
                check_value("frame_count", v.exp_frames - v.exp_eof, frame_count);
                prev_beat = exp_beat;
                final_beats = v.exp_beats;
                final_frames = v.exp_frames;
                @(posedge clk);
                pix_req <= 1'b0;
                wait_ack(1'b0, 1'b0, n);
            end
        end

        // Last beat drains with ready high
        repeat (3) @(negedge clk);
        check_value("stream_valid", 0, stream_valid);
        check_value("beat_count", final_beats, beat_count);
        check_value("frame_count", final_frames, frame_count);

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+include
logic/voxel_shell_pkg.sv
logic/window_decode.sv
logic/mem_access.sv
logic/pixel_framer.sv
logic/pixel_stream_out.sv
logic/voxel_shell_top.sv
bench/tb_voxel_shell.sv
